//--- logic/z80DecodePkg.sv
// Instruction-side types for the sequencer, the family decoders and the testbench.
`default_nettype none

package z80DecodePkg;

    // Execution phase, one cycle each.
    typedef enum logic [3:0] {
        stepFetch = 4'd0,
        step1 = 4'd1,
        step2 = 4'd2,
        step3 = 4'd3,
        step4 = 4'd4
    } phaseT;

    // Implemented opcodes of the 00xx0xxx family.
    typedef enum logic [7:0] {
        opNop = 8'h00,
        opLdBcNn = 8'h01,
        opLdBcIndA = 8'h02,
        opIncB = 8'h04,
        opDecB = 8'h05,
        opLdBN = 8'h06,
        opLdDeNn = 8'h11,
        opLdDeIndA = 8'h12,
        opIncD = 8'h14,
        opDecD = 8'h15,
        opLdDN = 8'h16,
        opLdHlNn = 8'h21,
        opLdNnHl = 8'h22,
        opIncH = 8'h24,
        opDecH = 8'h25,
        opLdHN = 8'h26,
        opLdSpNn = 8'h31, // No SP here, operand is skipped.
        opLdNnA = 8'h32,
        opIncHlInd = 8'h34,
        opDecHlInd = 8'h35,
        opLdHlIndN = 8'h36
    } opcodeT;

endpackage

`default_nettype wire

//--- logic/z80DatapathPkg.sv
// Datapath-side types for the control strobes between the decoders and the datapath.
`default_nettype none

package z80DatapathPkg;

    localparam int addrWidth = 16;
    localparam int dataWidth = 8;

    // Zero means no register, so idle decoder outputs merge by OR.
    typedef enum logic [3:0] {
        regNone = 4'd0,
        regB = 4'd1,
        regC = 4'd2,
        regD = 4'd3,
        regE = 4'd4,
        regH = 4'd5,
        regL = 4'd6,
        regA = 4'd7,
        regDt = 4'd8,
        regDtex = 4'd9
    } regCodeT;

    typedef enum logic [2:0] {
        adrNone = 3'd0,
        adrPc = 3'd1,
        adrBc = 3'd2,
        adrDe = 3'd3,
        adrHl = 3'd4,
        adrTmp = 3'd5, // Dtex:Dt.
        adrTmpPlus1 = 3'd6
    } adrSelT;

    typedef enum logic [0:0] {
        srcMem = 1'b0,
        srcAlu = 1'b1
    } wrSrcT;

    typedef enum logic [1:0] {
        aluPass = 2'd0,
        aluInc = 2'd1,
        aluDec = 2'd2
    } aluOpT;

endpackage

`default_nettype wire

//--- logic/decoder000x0.sv
// Phase decoder for opcodes 0x00-0x17, instantiated by decoder00xx0; all outputs zero when idle.
`timescale 1ns/1ps
`default_nettype none

module decoder000x0 (
    input wire enable,
    input wire z80DecodePkg::phaseT step,
    input wire [7:0] opcode,
    output z80DatapathPkg::adrSelT adSelect,
    output z80DatapathPkg::regCodeT readSel,
    output z80DatapathPkg::aluOpT aluOp,
    output z80DatapathPkg::regCodeT writeSel,
    output z80DatapathPkg::wrSrcT writeSrc,
    output logic memWrite,
    output logic memRead,
    output logic pcInc,
    output logic resetStep
);

    z80DatapathPkg::regCodeT target;

    // Bits 5:3 are 000 for B and 010 for D.
    always_comb begin
        target = z80DatapathPkg::regB;
        if (opcode[4]) target = z80DatapathPkg::regD;
    end

    always_comb begin
        adSelect = z80DatapathPkg::adrNone;
        readSel = z80DatapathPkg::regNone;
        aluOp = z80DatapathPkg::aluPass;
        writeSel = z80DatapathPkg::regNone;
        writeSrc = z80DatapathPkg::srcMem;
        memWrite = 1'b0;
        memRead = 1'b0;
        pcInc = 1'b0;
        resetStep = 1'b0;
        if (enable) begin
            case (opcode)
                z80DecodePkg::opLdBcNn, z80DecodePkg::opLdDeNn: begin
                    adSelect = z80DatapathPkg::adrPc;
                    memRead = 1'b1;
                    pcInc = 1'b1;
                    if (step == z80DecodePkg::step1) begin
                        writeSel = z80DatapathPkg::regC; // Low byte first.
                        if (opcode[4]) writeSel = z80DatapathPkg::regE;
                    end else begin
                        writeSel = target;
                        resetStep = 1'b1;
                    end
                end
                z80DecodePkg::opLdBcIndA, z80DecodePkg::opLdDeIndA: begin
                    adSelect = z80DatapathPkg::adrBc;
                    if (opcode[4]) adSelect = z80DatapathPkg::adrDe;
                    readSel = z80DatapathPkg::regA;
                    memWrite = 1'b1;
                    resetStep = 1'b1;
                end
                z80DecodePkg::opIncB, z80DecodePkg::opDecB,
                z80DecodePkg::opIncD, z80DecodePkg::opDecD: begin
                    readSel = target;
                    aluOp = z80DatapathPkg::aluInc;
                    if (opcode[0]) aluOp = z80DatapathPkg::aluDec;
                    writeSel = target;
                    writeSrc = z80DatapathPkg::srcAlu;
                    resetStep = 1'b1;
                end
                z80DecodePkg::opLdBN, z80DecodePkg::opLdDN: begin
                    adSelect = z80DatapathPkg::adrPc;
                    memRead = 1'b1;
                    pcInc = 1'b1;
                    writeSel = target;
                    resetStep = 1'b1;
                end
                default: resetStep = 1'b1; // Columns 0, 3 and 7.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder001x0.sv
// Phase decoder for opcodes 0x20-0x37, instantiated by decoder00xx0; all outputs zero when idle.
`timescale 1ns/1ps
`default_nettype none

module decoder001x0 (
    input wire enable,
    input wire z80DecodePkg::phaseT step,
    input wire [7:0] opcode,
    output z80DatapathPkg::adrSelT adSelect,
    output z80DatapathPkg::regCodeT readSel,
    output z80DatapathPkg::aluOpT aluOp,
    output z80DatapathPkg::regCodeT writeSel,
    output z80DatapathPkg::wrSrcT writeSrc,
    output logic memWrite,
    output logic memRead,
    output logic pcInc,
    output logic resetStep
);

    always_comb begin
        adSelect = z80DatapathPkg::adrNone;
        readSel = z80DatapathPkg::regNone;
        aluOp = z80DatapathPkg::aluPass;
        writeSel = z80DatapathPkg::regNone;
        writeSrc = z80DatapathPkg::srcMem;
        memWrite = 1'b0;
        memRead = 1'b0;
        pcInc = 1'b0;
        resetStep = 1'b0;
        if (enable) begin
            case (opcode)
                z80DecodePkg::opLdHlNn, z80DecodePkg::opLdSpNn: begin
                    adSelect = z80DatapathPkg::adrPc;
                    memRead = 1'b1;
                    pcInc = 1'b1;
                    if (step == z80DecodePkg::step1) begin
                        if (!opcode[4]) writeSel = z80DatapathPkg::regL;
                    end else begin
                        if (!opcode[4]) writeSel = z80DatapathPkg::regH;
                        resetStep = 1'b1;
                    end
                end
                ////////////////////////////////////////////////////////////
                // Stores through nn, gathered in Dtex:Dt.
                z80DecodePkg::opLdNnHl, z80DecodePkg::opLdNnA: begin
                    case (step)
                        z80DecodePkg::step1, z80DecodePkg::step2: begin
                            adSelect = z80DatapathPkg::adrPc;
                            memRead = 1'b1;
                            pcInc = 1'b1;
                            writeSel = z80DatapathPkg::regDt;
                            if (step == z80DecodePkg::step2) writeSel = z80DatapathPkg::regDtex;
                        end
                        z80DecodePkg::step3: begin
                            adSelect = z80DatapathPkg::adrTmp;
                            memWrite = 1'b1;
                            readSel = z80DatapathPkg::regL;
                            if (opcode[4]) begin
                                readSel = z80DatapathPkg::regA; // LD (nn),A ends here.
                                resetStep = 1'b1;
                            end
                        end
                        default: begin
                            adSelect = z80DatapathPkg::adrTmpPlus1;
                            memWrite = 1'b1;
                            readSel = z80DatapathPkg::regH;
                            resetStep = 1'b1;
                        end
                    endcase
                end
                z80DecodePkg::opIncH, z80DecodePkg::opDecH: begin
                    readSel = z80DatapathPkg::regH;
                    aluOp = z80DatapathPkg::aluInc;
                    if (opcode[0]) aluOp = z80DatapathPkg::aluDec;
                    writeSel = z80DatapathPkg::regH;
                    writeSrc = z80DatapathPkg::srcAlu;
                    resetStep = 1'b1;
                end
                z80DecodePkg::opLdHN: begin
                    adSelect = z80DatapathPkg::adrPc;
                    memRead = 1'b1;
                    pcInc = 1'b1;
                    writeSel = z80DatapathPkg::regH;
                    resetStep = 1'b1;
                end
                ////////////////////////////////////////////////////////////
                // (HL) forms: operand into Dt, then ALU result back to (HL).
                z80DecodePkg::opIncHlInd, z80DecodePkg::opDecHlInd,
                z80DecodePkg::opLdHlIndN: begin
                    if (step == z80DecodePkg::step1) begin
                        adSelect = z80DatapathPkg::adrHl;
                        memRead = 1'b1;
                        writeSel = z80DatapathPkg::regDt;
                        if (opcode[1]) begin
                            adSelect = z80DatapathPkg::adrPc; // Immediate n.
                            pcInc = 1'b1;
                        end
                    end else begin
                        adSelect = z80DatapathPkg::adrHl;
                        readSel = z80DatapathPkg::regDt;
                        if (opcode[1:0] == 2'b00) aluOp = z80DatapathPkg::aluInc;
                        if (opcode[1:0] == 2'b01) aluOp = z80DatapathPkg::aluDec;
                        memWrite = 1'b1;
                        resetStep = 1'b1;
                    end
                end
                default: resetStep = 1'b1; // Columns 0, 3 and 7.
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder00xx0.sv
// Decoder for the 00xx0xxx family; splits on opcode bit 5 and ORs the two halves together.
`timescale 1ns/1ps
`default_nettype none

module decoder00xx0 (
    input wire enable,
    input wire z80DecodePkg::phaseT step,
    input wire [7:0] opcode,
    output z80DatapathPkg::adrSelT adSelect,
    output z80DatapathPkg::regCodeT readSel,
    output z80DatapathPkg::aluOpT aluOp,
    output z80DatapathPkg::regCodeT writeSel,
    output z80DatapathPkg::wrSrcT writeSrc,
    output logic memWrite,
    output logic memRead,
    output logic pcInc,
    output logic resetStep
);

    logic enable0, enable1;
    z80DatapathPkg::adrSelT adSelect0, adSelect1;
    z80DatapathPkg::regCodeT readSel0, readSel1, writeSel0, writeSel1;
    z80DatapathPkg::aluOpT aluOp0, aluOp1;
    z80DatapathPkg::wrSrcT writeSrc0, writeSrc1;
    logic memWrite0, memWrite1, memRead0, memRead1;
    logic pcInc0, pcInc1, resetStep0, resetStep1;

    assign enable0 = enable && !opcode[5]; // 0x00-0x17.
    assign enable1 = enable && opcode[5]; // 0x20-0x37.

    decoder000x0 d000x0 (
        .enable(enable0),
        .step(step),
        .opcode(opcode),
        .adSelect(adSelect0),
        .readSel(readSel0),
        .aluOp(aluOp0),
        .writeSel(writeSel0),
        .writeSrc(writeSrc0),
        .memWrite(memWrite0),
        .memRead(memRead0),
        .pcInc(pcInc0),
        .resetStep(resetStep0)
    );

    decoder001x0 d001x0 (
        .enable(enable1),
        .step(step),
        .opcode(opcode),
        .adSelect(adSelect1),
        .readSel(readSel1),
        .aluOp(aluOp1),
        .writeSel(writeSel1),
        .writeSrc(writeSrc1),
        .memWrite(memWrite1),
        .memRead(memRead1),
        .pcInc(pcInc1),
        .resetStep(resetStep1)
    );

    // The idle half drives zeros.
    assign adSelect = z80DatapathPkg::adrSelT'(adSelect0 | adSelect1);
    assign readSel = z80DatapathPkg::regCodeT'(readSel0 | readSel1);
    assign aluOp = z80DatapathPkg::aluOpT'(aluOp0 | aluOp1);
    assign writeSel = z80DatapathPkg::regCodeT'(writeSel0 | writeSel1);
    assign writeSrc = z80DatapathPkg::wrSrcT'(writeSrc0 | writeSrc1);
    assign memWrite = memWrite0 | memWrite1;
    assign memRead = memRead0 | memRead1;
    assign pcInc = pcInc0 | pcInc1;
    assign resetStep = resetStep0 | resetStep1;

endmodule

`default_nettype wire

//--- logic/seqControl.sv
// Instruction sequencer: opcode fetch, instruction register and phase counter for the core.
`timescale 1ns/1ps
`default_nettype none

module seqControl (
    input wire clk,
    input wire rstN,
    input wire [z80DatapathPkg::dataWidth-1:0] memRdData,
    input wire z80DatapathPkg::adrSelT decAdSelect,
    input wire z80DatapathPkg::regCodeT decReadSel,
    input wire z80DatapathPkg::aluOpT decAluOp,
    input wire z80DatapathPkg::regCodeT decWriteSel,
    input wire z80DatapathPkg::wrSrcT decWriteSrc,
    input wire decMemWrite,
    input wire decMemRead,
    input wire decPcInc,
    input wire decResetStep,
    output logic [7:0] opcode,
    output z80DecodePkg::phaseT step,
    output logic decEnable,
    output logic m1,
    output z80DatapathPkg::adrSelT adSelect,
    output z80DatapathPkg::regCodeT readSel,
    output z80DatapathPkg::aluOpT aluOp,
    output z80DatapathPkg::regCodeT writeSel,
    output z80DatapathPkg::wrSrcT writeSrc,
    output logic memWrite,
    output logic memRead,
    output logic pcInc
);

    logic inFamily;
    logic lastStep;

    assign inFamily = (opcode[7:6] == 2'b00) && !opcode[3];
    assign m1 = (step == z80DecodePkg::stepFetch);
    assign decEnable = inFamily && !m1;
    // Anything outside the family ends after step1.
    assign lastStep = decResetStep || (!inFamily && step == z80DecodePkg::step1);

    // Decoder is quiet during fetch, so its strobes pass straight on.
    assign readSel = decReadSel;
    assign aluOp = decAluOp;
    assign writeSel = decWriteSel;
    assign writeSrc = decWriteSrc;
    assign memWrite = decMemWrite;

    always_comb begin
        adSelect = decAdSelect;
        memRead = decMemRead;
        pcInc = decPcInc;
        if (m1) begin
            adSelect = z80DatapathPkg::adrPc; // Opcode read at PC.
            memRead = 1'b1;
            pcInc = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            step <= z80DecodePkg::stepFetch;
            opcode <= 8'h00;
        end else if (m1) begin
            opcode <= memRdData;
            step <= z80DecodePkg::step1;
        end else if (lastStep) begin
            step <= z80DecodePkg::stepFetch;
        end else begin
            step <= z80DecodePkg::phaseT'(step + 4'd1);
        end
    end

endmodule

`default_nettype wire

//--- logic/dataPath.sv
// Core datapath: register file, PC, operand latch, address mux and INC/DEC unit.
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
    parameter logic [z80DatapathPkg::addrWidth-1:0] resetPc = '0
) (
    input wire clk,
    input wire rstN,
    input wire z80DatapathPkg::adrSelT adSelect,
    input wire z80DatapathPkg::regCodeT readSel,
    input wire z80DatapathPkg::aluOpT aluOp,
    input wire z80DatapathPkg::regCodeT writeSel,
    input wire z80DatapathPkg::wrSrcT writeSrc,
    input wire pcInc,
    input wire [z80DatapathPkg::dataWidth-1:0] memRdData,
    output logic [z80DatapathPkg::addrWidth-1:0] memAddr,
    output logic [z80DatapathPkg::dataWidth-1:0] memWrData
);

    localparam int dataW = z80DatapathPkg::dataWidth;

    logic [dataW-1:0] b, c, d, e, h, l, a;
    logic [dataW-1:0] dt, dtex; // Operand latch, nn or (HL).
    logic [z80DatapathPkg::addrWidth-1:0] pc;
    logic [dataW-1:0] operand, aluOut, wrData;

    always_comb begin
        case (readSel)
            z80DatapathPkg::regB: operand = b;
            z80DatapathPkg::regC: operand = c;
            z80DatapathPkg::regD: operand = d;
            z80DatapathPkg::regE: operand = e;
            z80DatapathPkg::regH: operand = h;
            z80DatapathPkg::regL: operand = l;
            z80DatapathPkg::regA: operand = a;
            z80DatapathPkg::regDt: operand = dt;
            z80DatapathPkg::regDtex: operand = dtex;
            default: operand = '0;
        endcase
        case (aluOp)
            z80DatapathPkg::aluInc: aluOut = operand + 1'b1; // Wraps at 0xFF.
            z80DatapathPkg::aluDec: aluOut = operand - 1'b1;
            default: aluOut = operand;
        endcase
        case (adSelect)
            z80DatapathPkg::adrPc: memAddr = pc;
            z80DatapathPkg::adrBc: memAddr = {b, c};
            z80DatapathPkg::adrDe: memAddr = {d, e};
            z80DatapathPkg::adrHl: memAddr = {h, l};
            z80DatapathPkg::adrTmp: memAddr = {dtex, dt};
            z80DatapathPkg::adrTmpPlus1: memAddr = {dtex, dt} + 1'b1;
            default: memAddr = '0;
        endcase
    end

    assign memWrData = aluOut;
    assign wrData = (writeSrc == z80DatapathPkg::srcAlu) ? aluOut : memRdData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            {b, c, d, e, h, l, a} <= '0;
            {dtex, dt} <= '0;
            pc <= resetPc;
        end else begin
            if (pcInc) pc <= pc + 1'b1;
            case (writeSel)
                z80DatapathPkg::regB: b <= wrData;
                z80DatapathPkg::regC: c <= wrData;
                z80DatapathPkg::regD: d <= wrData;
                z80DatapathPkg::regE: e <= wrData;
                z80DatapathPkg::regH: h <= wrData;
                z80DatapathPkg::regL: l <= wrData;
                z80DatapathPkg::regA: a <= wrData;
                z80DatapathPkg::regDt: dt <= wrData;
                z80DatapathPkg::regDtex: dtex <= wrData;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/z80Lite.sv
// Top level of the Z80-style execution slice; connect clk, rstN and the external memory bus.
`timescale 1ns/1ps
`default_nettype none

module z80Lite #(
    parameter logic [z80DatapathPkg::addrWidth-1:0] resetPc = '0
) (
    input wire clk,
    input wire rstN,
    output logic [z80DatapathPkg::addrWidth-1:0] memAddr,
    input wire [z80DatapathPkg::dataWidth-1:0] memRdData,
    output logic [z80DatapathPkg::dataWidth-1:0] memWrData,
    output logic memWr,
    output logic memRd,
    output logic m1 // Opcode fetch cycle.
);

    logic [7:0] opcode;
    z80DecodePkg::phaseT step;
    logic decEnable;
    z80DatapathPkg::adrSelT decAdSelect, adSelect;
    z80DatapathPkg::regCodeT decReadSel, readSel, decWriteSel, writeSel;
    z80DatapathPkg::aluOpT decAluOp, aluOp;
    z80DatapathPkg::wrSrcT decWriteSrc, writeSrc;
    logic decMemWrite, decMemRead, decPcInc, decResetStep;
    logic pcInc;

    ////////////////////////////////////////////////////////////
    // Sequencer and family decoder.
    seqControl seq (
        .clk(clk),
        .rstN(rstN),
        .memRdData(memRdData),
        .decAdSelect(decAdSelect),
        .decReadSel(decReadSel),
        .decAluOp(decAluOp),
        .decWriteSel(decWriteSel),
        .decWriteSrc(decWriteSrc),
        .decMemWrite(decMemWrite),
        .decMemRead(decMemRead),
        .decPcInc(decPcInc),
        .decResetStep(decResetStep),
        .opcode(opcode),
        .step(step),
        .decEnable(decEnable),
        .m1(m1),
        .adSelect(adSelect),
        .readSel(readSel),
        .aluOp(aluOp),
        .writeSel(writeSel),
        .writeSrc(writeSrc),
        .memWrite(memWr),
        .memRead(memRd),
        .pcInc(pcInc)
    );

    decoder00xx0 dec (
        .enable(decEnable),
        .step(step),
        .opcode(opcode),
        .adSelect(decAdSelect),
        .readSel(decReadSel),
        .aluOp(decAluOp),
        .writeSel(decWriteSel),
        .writeSrc(decWriteSrc),
        .memWrite(decMemWrite),
        .memRead(decMemRead),
        .pcInc(decPcInc),
        .resetStep(decResetStep)
    );

    ////////////////////////////////////////////////////////////
    // Datapath.
    dataPath #(
        .resetPc(resetPc)
    ) dp (
        .clk(clk),
        .rstN(rstN),
        .adSelect(adSelect),
        .readSel(readSel),
        .aluOp(aluOp),
        .writeSel(writeSel),
        .writeSrc(writeSrc),
        .pcInc(pcInc),
        .memRdData(memRdData),
        .memAddr(memAddr),
        .memWrData(memWrData)
    );

endmodule

`default_nettype wire

//--- tests/z80LiteTb.sv
// Testbench for z80Lite: runs directed and random programs against a reference model of the ISA.
`timescale 1ns/1ps
`default_nettype none

module z80LiteTb;

    localparam logic [15:0] resetPc = 16'h0100;

    logic clk = 1'b0;
    logic rstN;
    logic [15:0] memAddr;
    logic [7:0] memRdData;
    logic [7:0] memWrData;
    logic memWr;
    logic memRd;
    logic m1;

    logic [7:0] mem [0:65535];
    logic [7:0] modelMem [0:65535];
    logic [7:0] mReg [0:7]; // Z80 order: B C D E H L (HL) A.
    logic [15:0] mPc;
    logic [15:0] expAddr [$];
    logic [7:0] expData [$];
    int expCycles;
    logic [7:0] prog [$];
    int numInstr = 0;
    logic [31:0] seed = 32'h0f6a_df3b;
    int testErrors = 0;
    int totalErrors = 0;
    int passCount = 0;
    int failCount = 0;
    logic lost;

    z80Lite #(
        .resetPc(resetPc)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .memAddr(memAddr),
        .memRdData(memRdData),
        .memWrData(memWrData),
        .memWr(memWr),
        .memRd(memRd),
        .m1(m1)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Memory: combinational read, write at the rising edge.
    assign memRdData = mem[memAddr];

    always @(posedge clk) begin
        if (memWr === 1'b1) mem[memAddr] <= memWrData;
    end

    function automatic logic [7:0] randByte();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[23:16];
    endfunction

    function automatic void reportFailure(input string msg);
        $display("%s", msg);
        testErrors++;
    endfunction

    function automatic void emitOp(input logic [7:0] b);
        prog.push_back(b);
        numInstr++;
    endfunction

    function automatic void emitByte(input logic [7:0] b);
        prog.push_back(b);
    endfunction

    function automatic void loadImage();
        logic [15:0] a;
        foreach (mem[i]) begin
            a = 16'(i);
            mem[a] = a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
            modelMem[a] = mem[a];
        end
        foreach (prog[i]) begin
            a = resetPc + 16'(i);
            mem[a] = prog[i];
            modelMem[a] = prog[i];
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference model, one whole instruction per call.
    function automatic logic [7:0] fetchByte();
        logic [7:0] b;
        b = modelMem[mPc];
        mPc = mPc + 16'd1;
        return b;
    endfunction

    function automatic void modelStore(input logic [15:0] addr, input logic [7:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
        modelMem[addr] = data;
    endfunction

    function automatic void execModel();
        logic [7:0] op;
        logic [2:0] r;
        logic [15:0] nn;
        logic [15:0] hl;
        logic [7:0] v;
        op = fetchByte();
        r = op[5:3];
        hl = {mReg[4], mReg[5]};
        expCycles = 2;
        if (op[7:6] == 2'b00 && !op[3]) begin
            case (op[2:0])
                3'd1: begin
                    nn[7:0] = fetchByte();
                    nn[15:8] = fetchByte();
                    expCycles = 3;
                    if (op[5:4] != 2'b11) begin // SP does not exist here.
                        mReg[{op[5:4], 1'b0}] = nn[15:8];
                        mReg[{op[5:4], 1'b1}] = nn[7:0];
                    end
                end
                3'd2: begin
                    if (!op[5]) begin
                        modelStore({mReg[{1'b0, op[4], 1'b0}], mReg[{1'b0, op[4], 1'b1}]},
                                   mReg[7]);
                    end else begin
                        nn[7:0] = fetchByte();
                        nn[15:8] = fetchByte();
                        if (op[4]) begin
                            modelStore(nn, mReg[7]);
                            expCycles = 4;
                        end else begin
                            modelStore(nn, mReg[5]);
                            modelStore(nn + 16'd1, mReg[4]);
                            expCycles = 5;
                        end
                    end
                end
                3'd4, 3'd5, 3'd6: begin
                    if (op[2:0] == 3'd6) v = fetchByte();
                    else if (r == 3'd6) v = modelMem[hl];
                    else v = mReg[r];
                    if (op[2:0] == 3'd4) v = v + 8'd1;
                    if (op[2:0] == 3'd5) v = v - 8'd1;
                    if (r == 3'd6) begin
                        modelStore(hl, v);
                        expCycles = 3;
                    end else begin
                        mReg[r] = v;
                    end
                end
                default: ; // Columns 0, 3 and 7.
            endcase
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Reset and lockstep comparison.
    task automatic applyReset();
        @(posedge clk);
        #2;
        rstN = 1'b0;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #2;
            if (i == 0) loadImage(); // Core is already held in reset.
            if (memWr !== 1'b0) reportFailure("memWr high during reset");
        end
        rstN = 1'b1;
        foreach (mReg[j]) mReg[j] = 8'h00;
        mPc = resetPc;
        expAddr.delete();
        expData.delete();
        lost = 1'b0;
        @(negedge clk);
        if (m1 !== 1'b1 || memRd !== 1'b1) begin
            reportFailure("m1 and memRd are not both high in the first cycle after reset");
        end
    endtask

    // Called at a falling edge with m1 high; returns at the next one.
    task automatic stepInstr();
        int cycles;
        logic [15:0] wa;
        logic [7:0] wd;
        cycles = 1;
        if (memAddr !== mPc) begin
            $display("mismatch memAddr: expected %h, got %h", mPc, memAddr);
            testErrors++;
        end
        if (memWr !== 1'b0) reportFailure("memWr high during an opcode fetch");
        execModel();
        @(negedge clk);
        while (m1 !== 1'b1 && cycles < 8) begin
            if (memWr === 1'b1) begin
                if (expAddr.size() == 0) begin
                    reportFailure($sformatf("unexpected write of %h to %h", memWrData, memAddr));
                end else begin
                    wa = expAddr.pop_front();
                    wd = expData.pop_front();
                    if (memAddr !== wa) begin
                        $display("mismatch memAddr: expected %h, got %h", wa, memAddr);
                        testErrors++;
                    end
                    if (memWrData !== wd) begin
                        $display("mismatch memWrData: expected %h, got %h", wd, memWrData);
                        testErrors++;
                    end
                end
            end
            cycles++;
            @(negedge clk);
        end
        if (m1 !== 1'b1) begin
            reportFailure("timed out waiting for the next opcode fetch");
            lost = 1'b1;
        end else if (cycles != expCycles) begin
            $display("mismatch cycles: expected %0h, got %0h", expCycles, cycles);
            testErrors++;
        end
        if (expAddr.size() != 0) begin
            reportFailure($sformatf("%0d expected writes did not happen", expAddr.size()));
            expAddr.delete();
            expData.delete();
        end
    endtask

    task automatic runProgram(input string name);
        testErrors = 0;
        applyReset();
        for (int i = 0; i < numInstr && !lost; i++) stepInstr();
        // The fetch after the last instruction shows where it left PC.
        if (!lost && memAddr !== mPc) begin
            $display("mismatch memAddr: expected %h, got %h", mPc, memAddr);
            testErrors++;
        end
        if (testErrors == 0) passCount++;
        else failCount++;
        $display("%-12s %0d instructions, %0d errors, %s", name, numInstr, testErrors,
                 (testErrors == 0) ? "ok" : "failed");
        totalErrors += testErrors;
        prog.delete();
        numInstr = 0;
    endtask

    ////////////////////////////////////////////////////////////
    initial begin
        logic [7:0] op;
        logic [7:0] n;
        logic [1:0] q2;
        rstN = 1'b0;
        loadImage();

        emitOp(z80DecodePkg::opNop);
        emitOp(z80DecodePkg::opNop);
        emitOp(z80DecodePkg::opLdBcIndA); // First store, A at 0x0000.
        runProgram("reset");

        emitOp(z80DecodePkg::opLdBcNn);
        emitByte(randByte());
        emitByte(randByte());
        emitOp(z80DecodePkg::opLdDeNn);
        emitByte(randByte());
        emitByte(randByte());
        emitOp(z80DecodePkg::opLdHlNn);
        emitByte(randByte());
        emitByte(randByte());
        emitOp(z80DecodePkg::opLdBcIndA);
        emitOp(z80DecodePkg::opLdDeIndA);
        emitOp(z80DecodePkg::opLdNnHl);
        emitByte(randByte());
        emitByte(randByte());
        emitOp(z80DecodePkg::opLdNnA);
        emitByte(randByte());
        emitByte(randByte());
        runProgram("loadStore");

        for (int k = 0; k < 6; k++) begin
            for (int q = 0; q < 3; q++) begin
                q2 = q[1:0]; // B, D, H.
                n = randByte();
                if (k == 0) n = 8'hff;
                if (k == 1) n = 8'h00;
                emitOp({2'b00, q2, 4'b0110});
                emitByte(n);
                op = randByte();
                if (k == 0) op[0] = 1'b0; // INC from 0xFF.
                if (k == 1) op[0] = 1'b1; // DEC from 0x00.
                emitOp({2'b00, q2, 3'b010, op[0]});
                if (q2 == 2'd2) begin
                    emitOp(z80DecodePkg::opLdNnHl);
                    emitByte(randByte());
                    emitByte(randByte());
                end else begin
                    emitOp({2'b00, q2, 4'b0010});
                end
            end
        end
        runProgram("incDecReg");

        for (int k = 0; k < 6; k++) begin
            emitOp(z80DecodePkg::opLdHlNn);
            emitByte(randByte());
            emitByte(randByte());
            n = randByte();
            if (k == 0) n = 8'hff;
            if (k == 1) n = 8'h00;
            emitOp(z80DecodePkg::opLdHlIndN);
            emitByte(n);
            emitOp(k[0] ? z80DecodePkg::opDecHlInd : z80DecodePkg::opIncHlInd);
            emitOp(z80DecodePkg::opIncHlInd);
        end
        runProgram("incDecHl");

        for (int k = 0; k < 24; k++) begin
            op = randByte();
            if (op[7:6] == 2'b00 && !op[3]) op[2:0] = op[1] ? 3'd3 : (op[0] ? 3'd7 : 3'd0);
            if (k % 6 == 5) op = z80DecodePkg::opLdSpNn;
            emitOp(op);
            if (op == z80DecodePkg::opLdSpNn) begin
                emitByte(randByte());
                emitByte(randByte());
            end
        end
        runProgram("nopClass");

        // Mostly family opcodes, the rest anything.
        for (int k = 0; k < 400; k++) begin
            op = randByte();
            if (randByte() < 8'd192) op = {2'b00, op[5:4], 1'b0, op[2:0]};
            emitOp(op);
            if (op[7:6] == 2'b00 && !op[3]) begin
                if (op[2:0] == 3'd1 || (op[2:0] == 3'd2 && op[5])) begin
                    emitByte(randByte());
                    emitByte(randByte());
                end
                if (op[2:0] == 3'd6) emitByte(randByte());
            end
        end
        runProgram("random");

        $display("tests: %0d passed, %0d failed, %0d errors", passCount, failCount, totalErrors);
        if (totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- z80Lite.f
logic/z80DecodePkg.sv
logic/z80DatapathPkg.sv
logic/decoder000x0.sv
logic/decoder001x0.sv
logic/decoder00xx0.sv
logic/seqControl.sv
logic/dataPath.sv
logic/z80Lite.sv
tests/z80LiteTb.sv

//--- run.sh
#!/bin/sh
# Build the z80Lite testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module z80LiteTb \
    -Mdir obj_dir -o z80LiteSim \
    -f z80Lite.f

./obj_dir/z80LiteSim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
